/* verilog/mq_cfg_pkg.sv */
// multi-queue packet buffer sizes
// queue count, buffer depth and the widths derived from them

package mq_cfg_pkg;

  // logical queues
  localparam int NUM_QUEUE  = 8;
  localparam int QUEUE_BITS = 3;

  // shared buffer entries
  localparam int NUM_ENTRY = 64;
  localparam int ADDR_BITS = 6;

  // counts run 0..NUM_ENTRY inclusive
  localparam int CNT_BITS = 7;

  localparam int DATA_BITS = 16; // stored word

  // cpu status port
  // top address bit picks free-list status, low bits pick a queue
  localparam int CPU_ADR_BITS = 4;
  localparam int CPU_BITS     = 19;

endpackage

/* verilog/mq_types_pkg.sv */
// multi-queue packet buffer cpu status types
// one status word, read either as queue state or as free-list state

package mq_types_pkg;

  // head, tail and entry count of one queue
  typedef struct packed {
    logic [mq_cfg_pkg::ADDR_BITS-1:0] head;
    logic [mq_cfg_pkg::ADDR_BITS-1:0] tail;
    logic [mq_cfg_pkg::CNT_BITS-1:0]  cnt;
  } mq_queue_state_t;

  // free entries and the next address to be handed out
  typedef struct packed {
    logic [mq_cfg_pkg::CNT_BITS-1:0]  free_cnt;
    logic [mq_cfg_pkg::ADDR_BITS-1:0] next_addr;
    logic [mq_cfg_pkg::CPU_BITS-mq_cfg_pkg::CNT_BITS-mq_cfg_pkg::ADDR_BITS-1:0] pad;
  } mq_free_state_t;

  // cp_adr msb selects which view is valid
  typedef union packed {
    mq_queue_state_t queue_st;
    mq_free_state_t  free_st;
  } mq_cpu_word_u;

endpackage

/* verilog/mq_mem_if.sv */
// buffer array bus
// one write port and one read port into a single array

`timescale 1ns/1ns

interface mq_mem_if #(
  parameter int WIDTH = mq_cfg_pkg::DATA_BITS
);

  logic                             wr_en;
  logic [mq_cfg_pkg::ADDR_BITS-1:0] wr_addr;
  logic [WIDTH-1:0]                 wr_data;
  logic [mq_cfg_pkg::ADDR_BITS-1:0] rd_addr;
  logic [WIDTH-1:0]                 rd_data;

  modport ctrl (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_addr,
    input  rd_data
  );

  modport store (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

/* verilog/mq_free_list.sv */
// free address list
// circular list of unused buffer addresses, alloc from the head, release to the tail

`timescale 1ns/1ns

module mq_free_list (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             alloc,
  input  logic                             release_en,
  input  logic [mq_cfg_pkg::ADDR_BITS-1:0] release_addr,
  output logic [mq_cfg_pkg::ADDR_BITS-1:0] alloc_addr,
  output logic [mq_cfg_pkg::CNT_BITS-1:0]  free_cnt
);

  logic [mq_cfg_pkg::ADDR_BITS-1:0] fl_mem [mq_cfg_pkg::NUM_ENTRY];
  logic [mq_cfg_pkg::ADDR_BITS-1:0] rd_ptr;
  logic [mq_cfg_pkg::ADDR_BITS-1:0] wr_ptr;
  logic [mq_cfg_pkg::CNT_BITS-1:0]  cnt;

  always_ff @(posedge clk) begin
    if (release_en) fl_mem[wr_ptr] <= release_addr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (alloc) rd_ptr <= rd_ptr + 1'b1; // pointers wrap at 64
      if (release_en) wr_ptr <= wr_ptr + 1'b1;
      case ({alloc, release_en})
        2'b10:   cnt <= cnt - 1'b1;
        2'b01:   cnt <= cnt + 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  assign alloc_addr = fl_mem[rd_ptr];
  assign free_cnt   = cnt;

  // a release in the same cycle cannot cover an alloc from an empty list
  assert_alloc_empty: assert property (@(posedge clk) disable iff (rst)
    alloc |-> (cnt != 0))
    else $error("free list alloc while empty");

  assert_release_full: assert property (@(posedge clk) disable iff (rst)
    release_en |-> (cnt != mq_cfg_pkg::CNT_BITS'(mq_cfg_pkg::NUM_ENTRY)))
    else $error("free list release while full");

endmodule

/* verilog/mq_buffer_store.sv */
// buffer store
// link array with flow-through read and data array with one cycle read latency
// every write is decided by the controller

`timescale 1ns/1ns

module mq_buffer_store (
  input logic    clk,
  mq_mem_if.store link_bus,
  mq_mem_if.store data_bus
);

  // next-entry pointer per buffer address
  logic [mq_cfg_pkg::ADDR_BITS-1:0] link_mem [mq_cfg_pkg::NUM_ENTRY];

  // packet words
  logic [mq_cfg_pkg::DATA_BITS-1:0] data_mem [mq_cfg_pkg::NUM_ENTRY];

  always_ff @(posedge clk) begin
    if (link_bus.wr_en) begin
      link_mem[link_bus.wr_addr] <= link_bus.wr_data;
    end
  end

  // same-cycle link read, needed to advance the head on a pop
  assign link_bus.rd_data = link_mem[link_bus.rd_addr];

  always_ff @(posedge clk) begin
    if (data_bus.wr_en) begin
      data_mem[data_bus.wr_addr] <= data_bus.wr_data;
    end
  end

  always_ff @(posedge clk) begin
    data_bus.rd_data <= data_mem[data_bus.rd_addr]; // registered, pop data at t+1
  end

endmodule

/* verilog/mq_queue_table.sv */
// queue pointer table
// head and tail register per queue, three read ports
// a push into an empty queue loads head and tail together

`timescale 1ns/1ns

module mq_queue_table (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              head_we,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0] head_q,
  input  logic [mq_cfg_pkg::ADDR_BITS-1:0]  head_addr,
  input  logic                              tail_we,
  input  logic                              head_load,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0] tail_q,
  input  logic [mq_cfg_pkg::ADDR_BITS-1:0]  tail_addr,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0] pop_q,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0] push_q,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0] cpu_q,
  output logic [mq_cfg_pkg::ADDR_BITS-1:0]  pop_head,
  output logic [mq_cfg_pkg::ADDR_BITS-1:0]  push_tail,
  output logic [mq_cfg_pkg::ADDR_BITS-1:0]  cpu_head,
  output logic [mq_cfg_pkg::ADDR_BITS-1:0]  cpu_tail
);

  logic [mq_cfg_pkg::ADDR_BITS-1:0] head [mq_cfg_pkg::NUM_QUEUE];
  logic [mq_cfg_pkg::ADDR_BITS-1:0] tail [mq_cfg_pkg::NUM_QUEUE];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int q = 0; q < mq_cfg_pkg::NUM_QUEUE; q++) begin
        head[q] <= '0;
        tail[q] <= '0;
      end
    end else begin
      if (tail_we) begin
        tail[tail_q] <= tail_addr;
        if (head_load) head[tail_q] <= tail_addr; // first entry is head and tail
      end
      if (head_we) head[head_q] <= head_addr;
    end
  end

  assign pop_head  = head[pop_q];
  assign push_tail = tail[push_q];
  assign cpu_head  = head[cpu_q];
  assign cpu_tail  = tail[cpu_q];

endmodule

/* verilog/mq_occupancy.sv */
// queue occupancy
// one entry counter per queue, push and pop may hit the same queue in one cycle
// flags pops from empty queues and pushes into a full buffer

`timescale 1ns/1ns

module mq_occupancy (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              ready,
  input  logic                              push,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0] push_q,
  input  logic                              pop,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0] pop_q,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0] cpu_q,
  output logic [mq_cfg_pkg::CNT_BITS-1:0]   pop_cnt,
  output logic [mq_cfg_pkg::CNT_BITS-1:0]   cpu_cnt
);

  logic [mq_cfg_pkg::CNT_BITS-1:0] occ_cnt     [mq_cfg_pkg::NUM_QUEUE];
  logic [mq_cfg_pkg::CNT_BITS-1:0] occ_cnt_nxt [mq_cfg_pkg::NUM_QUEUE];
  logic [mq_cfg_pkg::CNT_BITS-1:0] occ_total;

  always_comb begin
    for (int q = 0; q < mq_cfg_pkg::NUM_QUEUE; q++) begin
      occ_cnt_nxt[q] = occ_cnt[q];
    end
    if (ready && push) occ_cnt_nxt[push_q] = occ_cnt_nxt[push_q] + 1'b1;
    if (ready && pop) occ_cnt_nxt[pop_q] = occ_cnt_nxt[pop_q] - 1'b1; // nets out on same queue
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int q = 0; q < mq_cfg_pkg::NUM_QUEUE; q++) begin
        occ_cnt[q] <= '0;
      end
    end else begin
      for (int q = 0; q < mq_cfg_pkg::NUM_QUEUE; q++) begin
        occ_cnt[q] <= occ_cnt_nxt[q];
      end
    end
  end

  // entries held by all queues, equals 64 exactly when the free list is empty
  always_comb begin
    occ_total = '0;
    for (int q = 0; q < mq_cfg_pkg::NUM_QUEUE; q++) begin
      occ_total = occ_total + occ_cnt[q];
    end
  end

  assign pop_cnt = occ_cnt[pop_q];
  assign cpu_cnt = occ_cnt[cpu_q];

  assert_pop_empty: assert property (@(posedge clk) disable iff (rst || !ready)
    pop |-> (occ_cnt[pop_q] != 0))
    else $error("pop from empty queue %0d", pop_q);

  assert_push_full: assert property (@(posedge clk) disable iff (rst || !ready)
    push |-> (occ_total != mq_cfg_pkg::CNT_BITS'(mq_cfg_pkg::NUM_ENTRY)))
    else $error("push to queue %0d with no free entry", push_q);

endmodule

/* verilog/mq_ctrl.sv */
// multi-queue controller
// loads the free list after reset, sequences push and pop through the
// pointer table and the buffer store, and answers cpu status reads

`timescale 1ns/1ns

module mq_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                push,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0]   push_q,
  input  logic [mq_cfg_pkg::DATA_BITS-1:0]    push_data,
  input  logic                                pop,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0]   pop_q,
  input  logic                                cp_read,
  input  logic [mq_cfg_pkg::CPU_ADR_BITS-1:0] cp_adr,
  output logic                                ready,
  output logic                                po_dvld,
  output logic [mq_cfg_pkg::DATA_BITS-1:0]    po_dout,
  output logic                                cp_vld,
  output logic [mq_cfg_pkg::CPU_BITS-1:0]     cp_dout,
  // free list
  output logic                                alloc,
  output logic                                release_en,
  output logic [mq_cfg_pkg::ADDR_BITS-1:0]    release_addr,
  input  logic [mq_cfg_pkg::ADDR_BITS-1:0]    alloc_addr,
  input  logic [mq_cfg_pkg::CNT_BITS-1:0]     free_cnt,
  // queue table
  output logic                                head_we,
  output logic [mq_cfg_pkg::QUEUE_BITS-1:0]   head_q,
  output logic [mq_cfg_pkg::ADDR_BITS-1:0]    head_addr,
  output logic                                tail_we,
  output logic                                head_load,
  output logic [mq_cfg_pkg::QUEUE_BITS-1:0]   tail_q,
  output logic [mq_cfg_pkg::ADDR_BITS-1:0]    tail_addr,
  output logic [mq_cfg_pkg::QUEUE_BITS-1:0]   cpu_q,
  input  logic [mq_cfg_pkg::ADDR_BITS-1:0]    pop_head,
  input  logic [mq_cfg_pkg::ADDR_BITS-1:0]    push_tail,
  input  logic [mq_cfg_pkg::ADDR_BITS-1:0]    cpu_head,
  input  logic [mq_cfg_pkg::ADDR_BITS-1:0]    cpu_tail,
  // occupancy
  input  logic [mq_cfg_pkg::CNT_BITS-1:0]     pop_cnt,
  input  logic [mq_cfg_pkg::CNT_BITS-1:0]     cpu_cnt,
  mq_mem_if.ctrl                              link_bus,
  mq_mem_if.ctrl                              data_bus
);

  logic [mq_cfg_pkg::ADDR_BITS-1:0] init_cnt;
  logic [mq_cfg_pkg::NUM_QUEUE-1:0] q_live;   // queue holds at least one entry
  logic                             push_ok;
  logic                             pop_ok;
  logic                             same_q;
  logic                             last_pop; // pop at count 1, new head comes from the push
  mq_types_pkg::mq_cpu_word_u       cp_word;

  assign push_ok  = push && ready;
  assign pop_ok   = pop && ready;
  assign same_q   = push_ok && (push_q == pop_q);
  assign last_pop = pop_cnt == mq_cfg_pkg::CNT_BITS'(1);

  always_ff @(posedge clk) begin
    if (rst) begin
      init_cnt <= '0;
      ready    <= 1'b0;
    end else if (!ready) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == mq_cfg_pkg::ADDR_BITS'(mq_cfg_pkg::NUM_ENTRY - 1)) ready <= 1'b1;
    end
  end

  // init loads 0..63 in order, afterwards popped heads go back
  assign alloc        = push_ok;
  assign release_en   = !ready || pop_ok;
  assign release_addr = ready ? pop_head : init_cnt;

  assign data_bus.wr_en   = push_ok;
  assign data_bus.wr_addr = alloc_addr;
  assign data_bus.wr_data = push_data;
  assign data_bus.rd_addr = pop_head;

  // chain the new entry behind the old tail
  assign link_bus.wr_en   = push_ok && q_live[push_q];
  assign link_bus.wr_addr = push_tail;
  assign link_bus.wr_data = alloc_addr;
  assign link_bus.rd_addr = pop_head;

  assign tail_we   = push_ok;
  assign head_load = !q_live[push_q];
  assign tail_q    = push_q;
  assign tail_addr = alloc_addr;

  assign head_we   = pop_ok;
  assign head_q    = pop_q;
  assign head_addr = (same_q && last_pop) ? alloc_addr : link_bus.rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      q_live <= '0;
    end else begin
      if (pop_ok && last_pop && !same_q) q_live[pop_q] <= 1'b0;
      if (push_ok) q_live[push_q] <= 1'b1;
    end
  end

  assign po_dout = data_bus.rd_data;
  assign cpu_q   = cp_adr[mq_cfg_pkg::QUEUE_BITS-1:0];

  always_comb begin
    cp_word = '0;
    if (cp_adr[mq_cfg_pkg::CPU_ADR_BITS-1]) begin
      cp_word.free_st.free_cnt  = free_cnt;
      cp_word.free_st.next_addr = alloc_addr;
    end else begin
      cp_word.queue_st.head = cpu_head;
      cp_word.queue_st.tail = cpu_tail;
      cp_word.queue_st.cnt  = cpu_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      po_dvld <= 1'b0;
      cp_vld  <= 1'b0;
    end else begin
      po_dvld <= pop_ok;
      cp_vld  <= cp_read;
    end
  end

  always_ff @(posedge clk) begin
    cp_dout <= cp_word; // state before this cycle's push and pop
  end

endmodule

/* verilog/mq_top.sv */
// multi-queue packet buffer
// eight linked-list queues sharing one 64-entry buffer, with a cpu status port

`timescale 1ns/1ns

module mq_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                push,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0]   pu_prt,
  input  logic [mq_cfg_pkg::DATA_BITS-1:0]    pu_din,
  input  logic                                pop,
  input  logic [mq_cfg_pkg::QUEUE_BITS-1:0]   po_prt,
  input  logic                                cp_read,
  input  logic [mq_cfg_pkg::CPU_ADR_BITS-1:0] cp_adr,
  output logic                                ready,
  output logic                                po_dvld,
  output logic [mq_cfg_pkg::DATA_BITS-1:0]    po_dout,
  output logic                                cp_vld,
  output logic [mq_cfg_pkg::CPU_BITS-1:0]     cp_dout
);

  logic                              alloc;
  logic                              release_en;
  logic [mq_cfg_pkg::ADDR_BITS-1:0]  release_addr;
  logic [mq_cfg_pkg::ADDR_BITS-1:0]  alloc_addr;
  logic [mq_cfg_pkg::CNT_BITS-1:0]   free_cnt;
  logic                              head_we;
  logic [mq_cfg_pkg::QUEUE_BITS-1:0] head_q;
  logic [mq_cfg_pkg::ADDR_BITS-1:0]  head_addr;
  logic                              tail_we;
  logic                              head_load;
  logic [mq_cfg_pkg::QUEUE_BITS-1:0] tail_q;
  logic [mq_cfg_pkg::ADDR_BITS-1:0]  tail_addr;
  logic [mq_cfg_pkg::QUEUE_BITS-1:0] cpu_q;
  logic [mq_cfg_pkg::ADDR_BITS-1:0]  pop_head;
  logic [mq_cfg_pkg::ADDR_BITS-1:0]  push_tail;
  logic [mq_cfg_pkg::ADDR_BITS-1:0]  cpu_head;
  logic [mq_cfg_pkg::ADDR_BITS-1:0]  cpu_tail;
  logic [mq_cfg_pkg::CNT_BITS-1:0]   pop_cnt;
  logic [mq_cfg_pkg::CNT_BITS-1:0]   cpu_cnt;

  mq_mem_if #(.WIDTH(mq_cfg_pkg::ADDR_BITS)) link_bus ();
  mq_mem_if #(.WIDTH(mq_cfg_pkg::DATA_BITS)) data_bus ();

  mq_ctrl u_ctrl (
    .clk, .rst,
    .push, .push_q(pu_prt), .push_data(pu_din),
    .pop, .pop_q(po_prt),
    .cp_read, .cp_adr,
    .ready, .po_dvld, .po_dout, .cp_vld, .cp_dout,
    .alloc, .release_en, .release_addr, .alloc_addr, .free_cnt,
    .head_we, .head_q, .head_addr,
    .tail_we, .head_load, .tail_q, .tail_addr, .cpu_q,
    .pop_head, .push_tail, .cpu_head, .cpu_tail,
    .pop_cnt, .cpu_cnt,
    .link_bus(link_bus.ctrl),
    .data_bus(data_bus.ctrl)
  );

  mq_free_list u_free_list (
    .clk, .rst, .alloc, .release_en, .release_addr, .alloc_addr, .free_cnt
  );

  mq_buffer_store u_store (
    .clk, .link_bus(link_bus.store), .data_bus(data_bus.store)
  );

  mq_queue_table u_queue_table (
    .clk, .rst,
    .head_we, .head_q, .head_addr,
    .tail_we, .head_load, .tail_q, .tail_addr,
    .pop_q(po_prt), .push_q(pu_prt), .cpu_q,
    .pop_head, .push_tail, .cpu_head, .cpu_tail
  );

  mq_occupancy u_occupancy (
    .clk, .rst, .ready,
    .push, .push_q(pu_prt), .pop, .pop_q(po_prt), .cpu_q,
    .pop_cnt, .cpu_cnt
  );

endmodule

/* sim/mq_tb.sv */
// multi-queue packet buffer testbench
// directed tests against a model of eight queues and the free-address fifo

`timescale 1ns/1ns

module mq_tb;

  localparam int TIMEOUT = 200;

  logic        clk = 1'b0;
  logic        rst;
  logic        push;
  logic [2:0]  pu_prt;
  logic [15:0] pu_din;
  logic        pop;
  logic [2:0]  po_prt;
  logic        cp_read;
  logic [3:0]  cp_adr;
  logic        ready;
  logic        po_dvld;
  logic [15:0] po_dout;
  logic        cp_vld;
  logic [18:0] cp_dout;

  logic [15:0] data_q [8][$]; // words per queue
  logic [5:0]  addr_q [8][$]; // buffer address of each word
  logic [5:0]  free_q [$];
  logic [15:0] exp_pop [$];
  int          due_q [$];     // negedge on which each pop word is due
  logic [15:0] exp_word;
  int          exp_due;
  int          neg_cnt = 0;
  int          errors = 0;
  string       test_name = "reset";

  mq_top UUT (.*);

  always #5 clk = ~clk;

  always @(negedge clk) begin
    neg_cnt++;
    if (po_dvld) begin
      assert (exp_pop.size() != 0)
        else begin
          errors++;
          $display("[FAIL] %s: po_dvld without an outstanding pop", test_name);
        end
      if (exp_pop.size() != 0) begin
        exp_word = exp_pop.pop_front();
        exp_due  = due_q.pop_front();
        assert (po_dout == exp_word)
          else begin
            errors++;
            $display("[FAIL] %s pop data: expected %h, actual %h", test_name, exp_word, po_dout);
          end
        assert (neg_cnt == exp_due)
          else begin
            errors++;
            $display("[FAIL] %s pop latency: expected %0d, actual %0d", test_name, exp_due, neg_cnt);
          end
      end
    end
  end

  task automatic check_value(input string what, input logic [18:0] exp, input logic [18:0] act);
    assert (act == exp)
      else begin
        errors++;
        $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
  endtask

  // random non-empty queue
  function automatic int pick_queue();
    int q;
    q = $urandom % 8;
    for (int i = 0; i < 8 && addr_q[q].size() == 0; i++) begin
      q = (q + 1) % 8;
    end
    return q;
  endfunction

  // one cycle of push and pop, the model moves to the state after the next edge
  task automatic step(input logic do_push, input int pq, input logic do_pop, input int oq);
    logic [15:0] word;
    logic [15:0] popped;
    logic [5:0]  released;
    word = 16'($urandom);
    if (do_pop) begin
      popped   = data_q[oq].pop_front();
      released = addr_q[oq].pop_front();
    end
    if (do_push) begin
      data_q[pq].push_back(word);
      addr_q[pq].push_back(free_q.pop_front());
    end
    if (do_pop) free_q.push_back(released); // alloc is taken before the release lands
    @(posedge clk);
    push   <= do_push;
    pu_prt <= 3'(pq);
    pu_din <= word;
    pop    <= do_pop;
    po_prt <= 3'(oq);
    if (do_pop) begin
      exp_pop.push_back(popped);
      due_q.push_back(neg_cnt + 2);
    end
  endtask

  task automatic wait_pops();
    int waited;
    step(0, 0, 0, 0);
    waited = 0;
    while (exp_pop.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    assert (exp_pop.size() == 0)
      else begin
        errors++;
        $display("[FAIL] %s: %0d pops never returned data", test_name, exp_pop.size());
        exp_pop.delete();
        due_q.delete();
      end
  endtask

  task automatic read_status(input logic [3:0] adr, output logic [18:0] word);
    int waited;
    @(posedge clk);
    push    <= 1'b0;
    pop     <= 1'b0;
    cp_read <= 1'b1;
    cp_adr  <= adr;
    waited  = 0;
    do begin
      @(posedge clk);
      cp_read <= 1'b0;
      @(negedge clk);
      waited++;
    end while (!cp_vld && waited < TIMEOUT);
    assert (cp_vld)
      else begin
        errors++;
        $display("[FAIL] %s: cp_vld never rose after a status read", test_name);
      end
    assert (waited == 1)
      else begin
        errors++;
        $display("[FAIL] %s status latency: expected 1, actual %0d", test_name, waited);
      end
    word = cp_dout;
  endtask

  task automatic check_free();
    logic [18:0] word;
    read_status(4'b1000, word);
    check_value("free status", {7'(free_q.size()), free_q[0], 6'd0}, word);
  endtask

  task automatic check_queue(input int q);
    logic [18:0] word;
    read_status({1'b0, 3'(q)}, word);
    if (addr_q[q].size() == 0)
      check_value($sformatf("queue %0d count", q), 19'd0, {12'd0, word[6:0]});
    else
      check_value($sformatf("queue %0d status", q),
                  {addr_q[q][0], addr_q[q][$], 7'(addr_q[q].size())}, word);
  endtask

  task automatic test_init();
    int waited;
    test_name = "init";
    check_value("outputs after reset", 19'd0, {16'd0, ready, po_dvld, cp_vld});
    waited = 0;
    while (!ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    assert (ready)
      else begin
        errors++;
        $display("[FAIL] init: ready did not rise within %0d cycles", TIMEOUT);
      end
    check_free();
  endtask

  task automatic test_fifo_order();
    test_name = "fifo_order";
    for (int i = 0; i < 12; i++) step(1, 2, 0, 0);
    for (int i = 0; i < 12; i++) step(0, 0, 1, 2);
    wait_pops();
  endtask

  task automatic test_interleave();
    test_name = "interleave";
    for (int i = 0; i < 24; i++) step(1, i % 8, 0, 0);
    for (int i = 0; i < 24; i++) step(0, 0, 1, pick_queue());
    wait_pops();
  endtask

  task automatic test_same_cycle();
    test_name = "same_cycle";
    for (int i = 0; i < 3; i++) step(1, 0, 0, 0);
    step(1, 5, 0, 0);
    step(1, 1, 1, 0); // different queues
    step(1, 5, 1, 5); // count 1, head taken from the push
    step(1, 5, 1, 5);
    step(1, 2, 1, 1); // q1 empties while q2 starts
    step(1, 0, 1, 0); // count above 1
    step(1, 0, 1, 0);
    while (free_q.size() != 64) step(0, 0, 1, pick_queue());
    wait_pops();
  endtask

  task automatic test_cpu_status();
    test_name = "cpu_status";
    for (int i = 0; i < 3; i++) step(1, 4, 0, 0);
    step(1, 6, 0, 0);
    step(1, 6, 1, 4);
    step(1, 4, 0, 0);
    check_queue(4);
    check_queue(6);
    check_queue(3);
    check_free();
    while (free_q.size() != 64) step(0, 0, 1, pick_queue());
    wait_pops();
  endtask

  task automatic test_fill_drain();
    test_name = "fill_drain";
    for (int i = 0; i < 64; i++) step(1, $urandom % 8, 0, 0);
    check_queue(pick_queue());
    while (free_q.size() != 64) step(0, 0, 1, pick_queue());
    wait_pops();
    check_free();
    for (int q = 0; q < 8; q++) check_queue(q);
  endtask

  initial begin
    void'($urandom(63314));
    for (int a = 0; a < 64; a++) free_q.push_back(6'(a)); // init load order
    rst     = 1'b1;
    push    = 1'b0;
    pu_prt  = '0;
    pu_din  = '0;
    pop     = 1'b0;
    po_prt  = '0;
    cp_read = 1'b0;
    cp_adr  = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_init();
    test_fifo_order();
    test_interleave();
    test_same_cycle();
    test_cpu_status();
    test_fill_drain();
    $display("checks failed: %0d", errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* flist.f */
verilog/mq_cfg_pkg.sv
verilog/mq_types_pkg.sv
verilog/mq_mem_if.sv
verilog/mq_free_list.sv
verilog/mq_buffer_store.sv
verilog/mq_queue_table.sv
verilog/mq_occupancy.sv
verilog/mq_ctrl.sv
verilog/mq_top.sv
sim/mq_tb.sv

/* run.sh */
#!/bin/sh
# build the multi-queue buffer testbench with verilator and run it
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f flist.f --top-module mq_tb -o mq_sim \
  && ./obj_dir/mq_sim | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
